//--- include/ecc_params.svh
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// ----------------------------------------------------------------------
// SECDED code geometry
// ----------------------------------------------------------------------

`define ECC_DATA_WIDTH   119   // Data bits in positions 3 to 126
`define ECC_PARITY_WIDTH 8     // Seven Hamming bits plus overall parity

// Hamming bits cover codeword positions 1 to 127
`define ECC_HAMMING_BITS 7

`endif

//--- design/ecc_pkg.sv
`include "ecc_params.svh"

package ecc_pkg;

    // ------------------------------------------------------------------
    // Word types
    // ------------------------------------------------------------------

    typedef logic [`ECC_DATA_WIDTH-1:0]   ecc_data_t;     // Also used for the mask
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_parity_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_syndrome_t;

    // Result of the syndrome decode before bypass is applied
    typedef struct packed {
        ecc_data_t mask;   // One hot on a correctable data error
        logic      sbit;   // Single error seen
        logic      dbit;   // Double or uncorrectable error seen
    } ecc_decode_t;

    // ------------------------------------------------------------------
    // Position map
    // ------------------------------------------------------------------

    // Data bits fill the codeword from position 3 upward and step over
    // every power of two, where the Hamming check bits sit
    function automatic logic [`ECC_HAMMING_BITS-1:0] ecc_data_position(
        input int unsigned idx
    );
        int unsigned pos;

        pos = idx + 3;   // Positions 1 and 2 are check bits
        for (int k = 2; k < `ECC_HAMMING_BITS; k++) begin
            if (pos >= (1 << k)) begin
                pos = pos + 1;   // Skip the check bit at 2**k
            end
        end
        return pos[`ECC_HAMMING_BITS-1:0];
    endfunction

endpackage

//--- design/ecc_encoder.sv
`include "ecc_params.svh"

module ecc_encoder
    import ecc_pkg::*;
(
    input  ecc_data_t   data,
    output ecc_parity_t parity
);

    // ------------------------------------------------------------------
    // Check bit generation
    // ------------------------------------------------------------------

    // Check bit i collects every data bit whose codeword position has
    // bit i set. The top bit collects the data bits at positions of even
    // popcount, which makes it the parity of the whole codeword
    always_comb begin
        logic [`ECC_HAMMING_BITS-1:0] pos;

        parity = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            pos = ecc_data_position(i);

            for (int b = 0; b < `ECC_HAMMING_BITS; b++) begin
                if (pos[b]) begin
                    parity[b] = parity[b] ^ data[i];
                end
            end

            if (!(^pos)) begin   // Even weight position
                parity[`ECC_HAMMING_BITS] = parity[`ECC_HAMMING_BITS] ^ data[i];
            end
        end
    end

endmodule

//--- design/ecc_syndrome_decoder.sv
`include "ecc_params.svh"

module ecc_syndrome_decoder
    import ecc_pkg::*;
(
    input  ecc_parity_t parity_in,
    input  ecc_parity_t parity_calc,
    output ecc_decode_t decode
);

    ecc_syndrome_t                syndrome;
    logic [`ECC_HAMMING_BITS-1:0] pos_field;    // Position named by the Hamming bits
    logic                         odd_weight;
    logic                         pos_is_data;
    logic                         pos_is_check;  // Zero or a power of two
    logic                         single_err;
    ecc_data_t                    match_mask;

    assign syndrome   = parity_in ^ parity_calc;
    assign pos_field  = syndrome[`ECC_HAMMING_BITS-1:0];
    assign odd_weight = ^syndrome;

    // ------------------------------------------------------------------
    // Position match
    // ------------------------------------------------------------------

    // Compare the position field with the codeword position of every data bit
    always_comb begin
        match_mask = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            match_mask[i] = (pos_field == ecc_data_position(i));
        end
    end

    assign pos_is_data  = |match_mask;
    assign pos_is_check = ($countones(pos_field) <= 1);

    // An odd syndrome is only correctable when it points at a real bit.
    // Position 127 holds nothing so it lands in the uncorrectable class
    assign single_err = odd_weight && (pos_is_data || pos_is_check);

    // ------------------------------------------------------------------
    // Classification
    // ------------------------------------------------------------------

    always_comb begin
        decode.mask = '0;
        decode.sbit = 1'b0;
        decode.dbit = 1'b0;

        if (syndrome != '0) begin
            if (single_err) begin
                decode.sbit = 1'b1;
                decode.mask = match_mask;   // Stays zero for a check bit error
            end else begin
                decode.dbit = 1'b1;
            end
        end
    end

endmodule

//--- design/ecc_output_stage.sv
module ecc_output_stage
    import ecc_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ecc_data_t   data_in,
    input  ecc_parity_t parity_calc,
    input  ecc_decode_t decode,
    input  logic        bypass,
    output ecc_data_t   data_out,
    output ecc_parity_t parity_out,
    output ecc_data_t   mask,
    output logic        sbit_err,
    output logic        dbit_err
);

    ecc_data_t data_sel;
    logic      sbit_sel;
    logic      dbit_sel;

    // ------------------------------------------------------------------
    // Correction and bypass
    // ------------------------------------------------------------------

    assign data_sel = bypass ? data_in : (data_in ^ decode.mask);
    assign sbit_sel = decode.sbit & ~bypass;   // Flags are quiet in bypass
    assign dbit_sel = decode.dbit & ~bypass;

    // ------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            data_out   <= '0;
            parity_out <= '0;
            mask       <= '0;
            sbit_err   <= 1'b0;
            dbit_err   <= 1'b0;
        end else begin
            data_out   <= data_sel;
            parity_out <= parity_calc;
            mask       <= decode.mask;   // Reported in both modes
            sbit_err   <= sbit_sel;
            dbit_err   <= dbit_sel;
        end
    end

endmodule

//--- design/ecc_119_top.sv
module ecc_119_top
    import ecc_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ecc_data_t   data_in,
    input  ecc_parity_t parity_in,
    input  logic        bypass,
    output ecc_data_t   data_out,
    output ecc_parity_t parity_out,
    output ecc_data_t   mask,
    output logic        sbit_err,
    output logic        dbit_err
);

    ecc_parity_t parity_calc;     // Check bits of the incoming data
    ecc_decode_t decode_result;

    // ------------------------------------------------------------------
    // Combinational check and decode
    // ------------------------------------------------------------------

    ecc_encoder u_encoder (
        .data   (data_in),
        .parity (parity_calc)
    );

    ecc_syndrome_decoder u_decoder (
        .parity_in   (parity_in),
        .parity_calc (parity_calc),
        .decode      (decode_result)
    );

    // One register stage for every output
    ecc_output_stage u_output_stage (
        .clk         (clk),
        .rst         (rst),
        .data_in     (data_in),
        .parity_calc (parity_calc),
        .decode      (decode_result),
        .bypass      (bypass),
        .data_out    (data_out),
        .parity_out  (parity_out),
        .mask        (mask),
        .sbit_err    (sbit_err),
        .dbit_err    (dbit_err)
    );

endmodule

//--- sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // ----------------------------------------------------------------------
    // Clock with a period of 20 and a reset held for three rising edges
    // ----------------------------------------------------------------------

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;   // Released on the third edge
    end

endmodule

//--- sim/ecc_119_tb.sv
`include "ecc_params.svh"

module ecc_119_tb
    import ecc_pkg::*;
;

    // Cycle budget of each test, also used for the cycle limit
    localparam int N_RESET   = 4;
    localparam int N_CLEAN   = 20;
    localparam int N_DATA    = `ECC_DATA_WIDTH;
    localparam int N_CHECK   = `ECC_PARITY_WIDTH;
    localparam int N_DOUBLE  = 40;
    localparam int N_POS127  = 4;
    localparam int N_BYPASS  = 30;
    localparam int N_MIXED   = 30;
    localparam int N_DRAIN   = 2;
    localparam int TOTAL_CYCLES = N_RESET + N_CLEAN + N_DATA + N_CHECK + N_DOUBLE
                                + N_POS127 + N_BYPASS + N_MIXED + N_DRAIN;
    localparam int TIMEOUT_CYCLES = TOTAL_CYCLES * 3 / 2;

    // Expected register contents for one word
    typedef struct packed {
        logic        valid;
        ecc_data_t   data_out;
        ecc_parity_t parity_out;
        ecc_data_t   mask;
        logic        sbit;
        logic        dbit;
    } expect_t;

    logic        clk;
    logic        rst;
    ecc_data_t   data_in;
    ecc_parity_t parity_in;
    logic        bypass;
    ecc_data_t   data_out;
    ecc_parity_t parity_out;
    ecc_data_t   mask;
    logic        sbit_err;
    logic        dbit_err;

    expect_t exp_next = '0;   // Goes with the inputs now on the DUT pins
    expect_t exp_cur  = '0;   // Goes with the registered outputs
    integer  seed;
    int      cycle_count = 0;
    int      pos_table [`ECC_DATA_WIDTH];

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    ecc_119_top DUT (
        .clk        (clk),
        .rst        (rst),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .data_out   (data_out),
        .parity_out (parity_out),
        .mask       (mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------

    // Walk the codeword and hand every non power of two to the next data bit
    task automatic build_position_table();
        int idx;

        idx = 0;
        for (int p = 1; p < 128; p++) begin
            if (((p & (p - 1)) != 0) && (idx < `ECC_DATA_WIDTH)) begin
                pos_table[idx] = p;
                idx++;
            end
        end
    endtask

    function automatic ecc_parity_t model_check(input ecc_data_t d);
        ecc_parity_t c;

        c = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            for (int b = 0; b < `ECC_HAMMING_BITS; b++) begin
                if (pos_table[i][b]) begin
                    c[b] = c[b] ^ d[i];
                end
            end
        end
        // Overall parity over data and the seven Hamming bits
        c[`ECC_HAMMING_BITS] = (^d) ^ (^c[`ECC_HAMMING_BITS-1:0]);
        return c;
    endfunction

    function automatic expect_t make_expect(
        input ecc_data_t din,
        input ecc_data_t exp_mask,
        input logic      exp_sbit,
        input logic      exp_dbit,
        input logic      byp
    );
        expect_t e;

        e.valid      = 1'b1;
        e.parity_out = model_check(din);
        e.mask       = exp_mask;
        e.data_out   = byp ? din : (din ^ exp_mask);
        e.sbit       = exp_sbit && !byp;
        e.dbit       = exp_dbit && !byp;
        return e;
    endfunction

    // ----------------------------------------------------------------------
    // Random helpers
    // ----------------------------------------------------------------------

    function automatic ecc_data_t random_word();
        logic [127:0] raw;

        raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
        return raw[`ECC_DATA_WIDTH-1:0];
    endfunction

    // Indices 0 to 118 are data bits, 119 to 126 are check bits
    function automatic int random_bit_index();
        int unsigned r;

        r = $random(seed);
        return r % (`ECC_DATA_WIDTH + `ECC_PARITY_WIDTH);
    endfunction

    task automatic add_flip(
        input  int          n,
        inout  ecc_data_t   dflip,
        inout  ecc_parity_t cflip
    );
        if (n < `ECC_DATA_WIDTH) begin
            dflip[n] = 1'b1;
        end else begin
            cflip[n - `ECC_DATA_WIDTH] = 1'b1;
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    task automatic drive_word(
        input ecc_data_t   word,
        input ecc_data_t   dflip,
        input ecc_parity_t cflip,
        input logic        byp,
        input ecc_data_t   exp_mask,
        input logic        exp_sbit,
        input logic        exp_dbit
    );
        ecc_data_t din;

        din = word ^ dflip;
        @(posedge clk);
        data_in   <= din;
        parity_in <= model_check(word) ^ cflip;   // Check bits of the original word
        bypass    <= byp;
        exp_next  <= make_expect(din, exp_mask, exp_sbit, exp_dbit, byp);
    endtask

    task automatic send_clean(input ecc_data_t word, input logic byp);
        drive_word(word, '0, '0, byp, '0, 1'b0, 1'b0);
    endtask

    task automatic send_data_flip(input ecc_data_t word, input int j, input logic byp);
        ecc_data_t dflip;

        dflip    = '0;
        dflip[j] = 1'b1;
        drive_word(word, dflip, '0, byp, dflip, 1'b1, 1'b0);
    endtask

    task automatic send_check_flip(input ecc_data_t word, input int k, input logic byp);
        ecc_parity_t cflip;

        cflip    = '0;
        cflip[k] = 1'b1;
        drive_word(word, '0, cflip, byp, '0, 1'b1, 1'b0);
    endtask

    task automatic send_double(input ecc_data_t word, input logic byp);
        int          a;
        int          b;
        ecc_data_t   dflip;
        ecc_parity_t cflip;

        a = random_bit_index();
        b = random_bit_index();
        while (b == a) begin
            b = random_bit_index();
        end
        dflip = '0;
        cflip = '0;
        add_flip(a, dflip, cflip);
        add_flip(b, dflip, cflip);
        drive_word(word, dflip, cflip, byp, '0, 1'b0, 1'b1);
    endtask

    // Odd weight syndrome whose position field names the empty slot 127
    task automatic send_pos127(input ecc_data_t word, input logic byp);
        drive_word(word, '0, 8'h7f, byp, '0, 1'b0, 1'b1);
    endtask

    // ----------------------------------------------------------------------
    // Checking
    // ----------------------------------------------------------------------

    task automatic report_mismatch(
        input string     name,
        input ecc_data_t expected,
        input ecc_data_t actual
    );
        $display("** Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("Done: errors found");
        $fatal(1, "Output mismatch");
    endtask

    // Outputs during reset must be zero whatever the inputs hold
    always @(posedge clk) begin
        if (rst) begin
            exp_cur <= '{1'b1, '0, '0, '0, 1'b0, 1'b0};
        end else begin
            exp_cur <= exp_next;
        end
    end

    always @(negedge clk) begin
        if (exp_cur.valid) begin
            assert (data_out === exp_cur.data_out)
                else report_mismatch("data_out", exp_cur.data_out, data_out);
            assert (parity_out === exp_cur.parity_out)
                else report_mismatch("parity_out", ecc_data_t'(exp_cur.parity_out),
                                     ecc_data_t'(parity_out));
            assert (mask === exp_cur.mask)
                else report_mismatch("mask", exp_cur.mask, mask);
            assert (sbit_err === exp_cur.sbit)
                else report_mismatch("sbit_err", ecc_data_t'(exp_cur.sbit),
                                     ecc_data_t'(sbit_err));
            assert (dbit_err === exp_cur.dbit)
                else report_mismatch("dbit_err", ecc_data_t'(exp_cur.dbit),
                                     ecc_data_t'(dbit_err));
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $fatal(1, "Cycle limit reached");
        end
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial begin
        ecc_data_t word;
        int        kind;
        logic      byp;

        seed = 4;
        build_position_table();

        // A single error word and then a double error word sit on the pins
        // through reset, so no register reads zero by chance
        word      = random_word();
        data_in   = {word[`ECC_DATA_WIDTH-1:1], ~word[0]};
        parity_in = model_check(word);
        bypass    = 1'b0;

        send_double(random_word(), 1'b0);   // Driven on the first reset edge
        while (rst) begin
            @(posedge clk);
        end

        for (int i = 0; i < N_CLEAN; i++) begin
            send_clean(random_word(), 1'b0);
        end
        for (int j = 0; j < N_DATA; j++) begin
            send_data_flip(random_word(), j, 1'b0);
        end
        for (int k = 0; k < N_CHECK; k++) begin
            send_check_flip(random_word(), k, 1'b0);
        end
        for (int i = 0; i < N_DOUBLE; i++) begin
            send_double(random_word(), 1'b0);
        end
        for (int i = 0; i < N_POS127; i++) begin
            send_pos127(random_word(), 1'b0);
        end

        // Bypass with every error class, the mask still reported
        for (int i = 0; i < N_BYPASS; i++) begin
            word = random_word();
            case (i % 4)
                0:       send_data_flip(word, random_bit_index() % N_DATA, 1'b1);
                1:       send_check_flip(word, i % N_CHECK, 1'b1);
                2:       send_double(word, 1'b1);
                default: send_pos127(word, 1'b1);
            endcase
        end

        // Every class back to back with random bypass
        for (int i = 0; i < N_MIXED; i++) begin
            word = random_word();
            kind = random_bit_index() % 5;
            byp  = ((random_bit_index() % 2) != 0);
            case (kind)
                0:       send_clean(word, byp);
                1:       send_data_flip(word, random_bit_index() % N_DATA, byp);
                2:       send_check_flip(word, random_bit_index() % N_CHECK, byp);
                3:       send_double(word, byp);
                default: send_pos127(word, byp);
            endcase
        end

        repeat (N_DRAIN) @(posedge clk);   // Last word checked on the negedge in between

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
design/ecc_pkg.sv
design/ecc_encoder.sv
design/ecc_syndrome_decoder.sv
design/ecc_output_stage.sv
design/ecc_119_top.sv
sim/tb_clock_gen.sv
sim/ecc_119_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the SECDED testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module ecc_119_tb \
    -f sources.f \
    -o ecc_119_sim

# A failing run exits nonzero, the search below decides the result
sim_out=$(./obj_dir/ecc_119_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q -x -F "Done: no errors"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
